// ==== logic/age_pkg.sv ====
/*
  shared types for the age-tracking back end
  sequence, tag and window index types
  commit notification, issue and age comparison structs
*/

`default_nettype none

package age_pkg;

  // ----------------------------------------------------------------------
  // widths and depths
  // ----------------------------------------------------------------------

  // default sequence width, the top level may override
  localparam int SEQ_BITS = 4;

  // entries in the issue window
  localparam int WIN_DEPTH = 4;

  // ----------------------------------------------------------------------
  // plain vector types
  // ----------------------------------------------------------------------

  typedef logic [SEQ_BITS-1:0] seq_num_t;

  // opaque payload, carried untouched from dispatch to issue
  typedef logic [7:0] tag_t;

  // slot number inside the window
  typedef logic [$clog2(WIN_DEPTH)-1:0] win_idx_t;

  // ----------------------------------------------------------------------
  // bundles
  // ----------------------------------------------------------------------

  // one retired instruction, one-cycle strobe
  typedef struct packed {
    logic     val;
    seq_num_t seq_num;
  } commit_notif_t;

  // oldest waiting entry presented by the window
  typedef struct packed {
    logic     val;
    seq_num_t seq_num;
    tag_t     tag;
  } issue_t;

  // is seq_a older than seq_b
  typedef struct packed {
    seq_num_t seq_a;
    seq_num_t seq_b;
  } cmp_pair_t;

endpackage

`default_nettype wire

// ==== logic/seq_alloc.sv ====
/*
  sequence number allocator
  next-sequence counter and in-flight count
  dispatch_full level for the front end
*/

`default_nettype none

module seq_alloc #(
  parameter int p_seq_bits = age_pkg::SEQ_BITS
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   dispatch_val,
  input  age_pkg::commit_notif_t commit,
  input  logic                   win_full,
  output age_pkg::seq_num_t      alloc_seq,
  output logic                   dispatch_full
);

  import age_pkg::*;

  // every number in the space may be in flight at once
  localparam int p_max_flight = 2 ** p_seq_bits;

  logic [p_seq_bits-1:0] next_seq;
  // one extra bit so a full space is representable
  logic [p_seq_bits:0]   in_flight;
  logic                  alloc;
  logic                  flight_full;

  // number for this cycle's dispatch, ready before the edge
  assign alloc_seq = seq_num_t'(next_seq);

  assign flight_full   = (in_flight == (p_seq_bits+1)'(p_max_flight));
  assign dispatch_full = flight_full || win_full;

  // ignore a dispatch the back end cannot take
  assign alloc = dispatch_val && !dispatch_full;

  // ----------------------------------------------------------------------
  // counters
  // ----------------------------------------------------------------------

  // wraps naturally at 2**p_seq_bits
  always_ff @(posedge clk) begin
    if (rst) begin
      next_seq <= '0;
    end else if (alloc) begin
      next_seq <= next_seq + 1'b1;
    end
  end

  // dispatch and commit in one cycle cancel out
  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      case ({alloc, commit.val})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/seq_age.sv ====
/*
  oldest in-flight sequence tracker
  wraparound-aware age comparators for the issue window
*/

`default_nettype none

module seq_age #(
  parameter int p_seq_bits = age_pkg::SEQ_BITS,
  parameter int p_num_cmp  = age_pkg::WIN_DEPTH - 1
) (
  input  logic                   clk,
  input  logic                   rst,
  input  age_pkg::commit_notif_t commit,
  input  age_pkg::cmp_pair_t     cmp [p_num_cmp],
  output logic [p_num_cmp-1:0]   older
);

  import age_pkg::*;

  // everything before this number has retired
  logic [p_seq_bits-1:0] oldest;

  always_ff @(posedge clk) begin
    if (rst) begin
      oldest <= '0;
    end else if (commit.val) begin
      oldest <= commit.seq_num[p_seq_bits-1:0] + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // age rule
  // ----------------------------------------------------------------------

  // plain compare when both lie on the same side of oldest
  // the answer flips when oldest lies between them
  function automatic logic is_older(
    input seq_num_t              seq_a,
    input seq_num_t              seq_b,
    input logic [p_seq_bits-1:0] base
  );
    logic [p_seq_bits-1:0] a;
    logic [p_seq_bits-1:0] b;
    a = seq_a[p_seq_bits-1:0];
    b = seq_b[p_seq_bits-1:0];
    return (a < b) ^ (a < base) ^ (b < base);
  endfunction

  // one comparator per tree node
  for (genvar i = 0; i < p_num_cmp; i++) begin : g_cmp
    assign older[i] = is_older(cmp[i].seq_a, cmp[i].seq_b, oldest);
  end

endmodule

`default_nettype wire

// ==== logic/issue_window.sv ====
/*
  four-entry issue window
  slot insertion at dispatch, oldest-first selection
  two-level tournament using external age comparators
*/

`default_nettype none

module issue_window #(
  parameter int p_win_depth = age_pkg::WIN_DEPTH
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     dispatch_val,
  input  age_pkg::seq_num_t        dispatch_seq,
  input  age_pkg::tag_t            dispatch_tag,
  input  logic                     stall,
  output age_pkg::cmp_pair_t       cmp [p_win_depth-1],
  input  logic [p_win_depth-2:0]   older,
  output logic                     win_full,
  output age_pkg::issue_t          issue
);

  import age_pkg::*;

  // first level pairs up neighbouring slots
  localparam int p_num_pair = p_win_depth / 2;

  // ----------------------------------------------------------------------
  // entry storage
  // ----------------------------------------------------------------------

  logic [p_win_depth-1:0] ent_val;
  seq_num_t               ent_seq [p_win_depth];
  tag_t                   ent_tag [p_win_depth];

  win_idx_t free_idx;
  logic     insert;
  logic     take;

  // tournament nodes
  logic     l1_val [p_num_pair];
  seq_num_t l1_seq [p_num_pair];
  tag_t     l1_tag [p_num_pair];
  win_idx_t l1_idx [p_num_pair];

  logic     fin_pick_a;
  win_idx_t win_idx;

  assign win_full = &ent_val;
  assign insert   = dispatch_val && !win_full;
  assign take     = issue.val && !stall;

  // lowest empty slot, scanned from the top so the last hit wins
  always_comb begin
    free_idx = '0;
    for (int i = p_win_depth - 1; i >= 0; i--) begin
      if (!ent_val[i]) begin
        free_idx = win_idx_t'(i);
      end
    end
  end

  // winner slot is valid, free slot is not, so they never collide
  always_ff @(posedge clk) begin
    if (rst) begin
      ent_val <= '0;
    end else begin
      if (take) begin
        ent_val[win_idx] <= 1'b0;
      end
      if (insert) begin
        ent_val[free_idx] <= 1'b1;
      end
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (insert) begin
      ent_seq[free_idx] <= dispatch_seq;
      ent_tag[free_idx] <= dispatch_tag;
    end
  end

  // ----------------------------------------------------------------------
  // level one: slot 2k against slot 2k+1
  // ----------------------------------------------------------------------

  for (genvar k = 0; k < p_num_pair; k++) begin : g_pair
    logic pick_a;

    assign cmp[k] = '{seq_a: ent_seq[2*k], seq_b: ent_seq[2*k+1]};

    // a wins when b is empty or a is older
    assign pick_a = ent_val[2*k] && (!ent_val[2*k+1] || older[k]);

    assign l1_val[k] = ent_val[2*k] || ent_val[2*k+1];
    assign l1_seq[k] = pick_a ? ent_seq[2*k] : ent_seq[2*k+1];
    assign l1_tag[k] = pick_a ? ent_tag[2*k] : ent_tag[2*k+1];
    assign l1_idx[k] = pick_a ? win_idx_t'(2*k) : win_idx_t'(2*k+1);
  end

  // ----------------------------------------------------------------------
  // level two: final between the two pair winners
  // ----------------------------------------------------------------------

  assign cmp[p_num_pair] = '{seq_a: l1_seq[0], seq_b: l1_seq[1]};

  assign fin_pick_a = l1_val[0] && (!l1_val[1] || older[p_num_pair]);

  assign win_idx = fin_pick_a ? l1_idx[0] : l1_idx[1];

  // presented straight from the registers, held while stalled
  assign issue = '{
    val:     l1_val[0] || l1_val[1],
    seq_num: fin_pick_a ? l1_seq[0] : l1_seq[1],
    tag:     fin_pick_a ? l1_tag[0] : l1_tag[1]
  };

endmodule

`default_nettype wire

// ==== logic/commit_unit.sv ====
/*
  completion scoreboard and in-order retirement
  one done bit per sequence number, head pointer
  registered commit notification
*/

`default_nettype none

module commit_unit #(
  parameter int p_seq_bits = age_pkg::SEQ_BITS
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   complete_val,
  input  age_pkg::seq_num_t      complete_seq,
  output age_pkg::commit_notif_t commit
);

  import age_pkg::*;

  localparam int p_num_seq = 2 ** p_seq_bits;

  // one bit per number in the sequence space
  logic [p_num_seq-1:0]  done;
  logic [p_seq_bits-1:0] head;
  logic                  retire;

  // outgoing pulse
  logic                  commit_val_q;
  logic [p_seq_bits-1:0] commit_seq_q;

  // finished head retires at this edge
  assign retire = done[head];

  // ----------------------------------------------------------------------
  // scoreboard
  // ----------------------------------------------------------------------

  // retired head bit clears while a completion sets its own bit
  always_ff @(posedge clk) begin
    if (rst) begin
      done <= '0;
    end else begin
      if (retire) begin
        done[head] <= 1'b0;
      end
      if (complete_val) begin
        done[complete_seq[p_seq_bits-1:0]] <= 1'b1;
      end
    end
  end

  // wraps with the allocator
  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
    end else if (retire) begin
      head <= head + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // commit notification
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_val_q <= 1'b0;
    end else begin
      commit_val_q <= retire;
    end
  end

  // number of the retired instruction
  always_ff @(posedge clk) begin
    if (retire) begin
      commit_seq_q <= head;
    end
  end

  assign commit = '{val: commit_val_q, seq_num: seq_num_t'(commit_seq_q)};

endmodule

`default_nettype wire

// ==== logic/age_backend.sv ====
/*
  age-tracking back end, top level
  allocator, issue window, age tracker, commit unit
*/

`default_nettype none

module age_backend #(
  parameter int p_seq_bits  = age_pkg::SEQ_BITS,
  parameter int p_win_depth = age_pkg::WIN_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst,

  // dispatch
  input  logic                   dispatch_val,
  input  age_pkg::tag_t          dispatch_tag,
  output logic                   dispatch_full,
  output age_pkg::seq_num_t      dispatch_seq,

  // issue
  input  logic                   stall,
  output age_pkg::issue_t        issue,

  // completion and retirement
  input  logic                   complete_val,
  input  age_pkg::seq_num_t      complete_seq,
  output age_pkg::commit_notif_t commit
);

  import age_pkg::*;

  localparam int p_num_cmp = p_win_depth - 1;

  // ----------------------------------------------------------------------
  // internal nets
  // ----------------------------------------------------------------------

  logic                 win_full;
  cmp_pair_t            cmp [p_num_cmp];
  logic [p_num_cmp-1:0] older;

  seq_alloc #(
    .p_seq_bits    (p_seq_bits)
  ) u_alloc (
    .clk           (clk),
    .rst           (rst),
    .dispatch_val  (dispatch_val),
    .commit        (commit),
    .win_full      (win_full),
    .alloc_seq     (dispatch_seq),
    .dispatch_full (dispatch_full)
  );

  issue_window #(
    .p_win_depth  (p_win_depth)
  ) u_window (
    .clk          (clk),
    .rst          (rst),
    .dispatch_val (dispatch_val),
    .dispatch_seq (dispatch_seq),
    .dispatch_tag (dispatch_tag),
    .stall        (stall),
    .cmp          (cmp),
    .older        (older),
    .win_full     (win_full),
    .issue        (issue)
  );

  // comparators serve the window's selection tree
  seq_age #(
    .p_seq_bits (p_seq_bits),
    .p_num_cmp  (p_num_cmp)
  ) u_age (
    .clk        (clk),
    .rst        (rst),
    .commit     (commit),
    .cmp        (cmp),
    .older      (older)
  );

  commit_unit #(
    .p_seq_bits   (p_seq_bits)
  ) u_commit (
    .clk          (clk),
    .rst          (rst),
    .complete_val (complete_val),
    .complete_seq (complete_seq),
    .commit       (commit)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_age_backend.sv ====
/*
  testbench for the age-tracking back end
  stimulus table applied in a loop, reference model of window,
  oldest number and commit order, compare task and watchdog
*/

`default_nettype none

module tb_age_backend;

  timeunit 1ns;
  timeprecision 100ps;

  import age_pkg::*;

  localparam int CLK_NS    = 8;
  localparam int RST_CYC   = 5;
  localparam int NUM_SEQ   = 16;
  localparam int NUM_ROWS  = 14;
  localparam int MARGIN_NS = 400;
  localparam logic [1:0] ANY = 2'd2;

  // one table row held for a number of cycles
  typedef struct packed {
    logic [7:0] cycles;
    logic       dispatch;
    logic       stall;
    logic       complete;
    logic [1:0] exp_full;  // expected full level entering the row
  } row_t;

  // cycles, dispatch, stall, complete, expected full
  // ANY as expected full skips the table check
  localparam row_t ROWS [NUM_ROWS] = '{
    '{8'd2,  1'b0, 1'b0, 1'b0, 2'd0},
    // fill the window under stall, then hold it full
    '{8'd4,  1'b1, 1'b1, 1'b0, 2'd0},
    '{8'd2,  1'b1, 1'b1, 1'b0, 2'd1},
    '{8'd3,  1'b0, 1'b0, 1'b0, 2'd1},
    // stream with no completions until 16 in flight
    '{8'd14, 1'b1, 1'b0, 1'b0, 2'd0},
    '{8'd16, 1'b0, 1'b0, 1'b1, 2'd1},
    '{8'd18, 1'b0, 1'b0, 1'b0, ANY},
    // stream with random completions and then drain
    '{8'd14, 1'b1, 1'b0, 1'b1, 2'd0},
    '{8'd20, 1'b0, 1'b0, 1'b1, ANY},
    // window holds 14, 15, 0, 1 across the wrap
    '{8'd4,  1'b1, 1'b1, 1'b0, 2'd0},
    '{8'd2,  1'b1, 1'b1, 1'b0, 2'd1},
    '{8'd4,  1'b0, 1'b0, 1'b0, 2'd1},
    '{8'd4,  1'b0, 1'b0, 1'b1, 2'd0},
    '{8'd6,  1'b0, 1'b0, 1'b0, ANY}
  };

  logic          clk;
  logic          rst;
  logic          dispatch_val;
  tag_t          dispatch_tag;
  logic          dispatch_full;
  seq_num_t      dispatch_seq;
  logic          stall;
  issue_t        issue;
  logic          complete_val;
  seq_num_t      complete_seq;
  commit_notif_t commit;

  // ----------------------------------------------------------------------
  // reference model state
  // ----------------------------------------------------------------------

  int   win_seq [$];
  int   win_tag [$];
  // issued but not yet completed
  int   pend_q [$];
  // dispatch order with the next to commit at the front
  int   order_q [$];
  logic done_bits [NUM_SEQ];
  int   m_next;
  int   m_flight;
  int   m_oldest;
  logic m_cval;
  int   m_cseq;
  int   seed;

  age_backend #(
    .p_seq_bits    (SEQ_BITS),
    .p_win_depth   (WIN_DEPTH)
  ) dut_i (
    .clk           (clk),
    .rst           (rst),
    .dispatch_val  (dispatch_val),
    .dispatch_tag  (dispatch_tag),
    .dispatch_full (dispatch_full),
    .dispatch_seq  (dispatch_seq),
    .stall         (stall),
    .issue         (issue),
    .complete_val  (complete_val),
    .complete_seq  (complete_seq),
    .commit        (commit)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic check_eq(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("ERR %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  // smallest distance past the oldest in-flight number is the oldest entry
  function automatic int pick_oldest();
    int best;
    int best_age;
    int age;
    best = -1;
    best_age = NUM_SEQ;
    foreach (win_seq[i]) begin
      age = (win_seq[i] - m_oldest + NUM_SEQ) % NUM_SEQ;
      if (age < best_age) begin
        best = i;
        best_age = age;
      end
    end
    return best;
  endfunction

  function automatic logic model_full();
    return (m_flight == NUM_SEQ) || (win_seq.size() == WIN_DEPTH);
  endfunction

  task automatic check_outputs(input logic [1:0] exp_full);
    int sel;
    sel = pick_oldest();
    check_eq(int'(dispatch_seq), m_next, "dispatch_seq");
    check_eq(int'(dispatch_full), int'(model_full()), "dispatch_full");
    if (exp_full != ANY) begin
      check_eq(int'(dispatch_full), int'(exp_full), "dispatch_full from table");
    end
    check_eq(int'(issue.val), int'(sel >= 0), "issue.val");
    if (sel >= 0) begin
      check_eq(int'(issue.seq_num), win_seq[sel], "issue.seq_num");
      check_eq(int'(issue.tag), win_tag[sel], "issue.tag");
    end
    check_eq(int'(commit.val), int'(m_cval), "commit.val");
    if (m_cval) begin
      check_eq(int'(commit.seq_num), m_cseq, "commit.seq_num");
    end
  endtask

  // drive one cycle on the falling edge and step the model past the next rise
  task automatic apply_cycle(input row_t row);
    logic alloc;
    logic retire;
    int   sel;
    int   pick;
    sel    = pick_oldest();
    alloc  = row.dispatch && !model_full();
    // head retires from done bits seen before this edge
    retire = (order_q.size() > 0) && done_bits[order_q[0]];
    dispatch_val = alloc;
    dispatch_tag = tag_t'($random(seed));
    stall        = row.stall;
    complete_val = 1'b0;
    complete_seq = '0;
    if (row.complete && pend_q.size() > 0) begin
      pick = int'({$random(seed)} % pend_q.size());
      complete_val = 1'b1;
      complete_seq = seq_num_t'(pend_q[pick]);
      done_bits[pend_q[pick]] = 1'b1;
      pend_q.delete(pick);
    end
    // commit pulse now visible moves oldest and frees one in flight
    if (m_cval) begin
      m_oldest = (m_cseq + 1) % NUM_SEQ;
    end
    m_flight = m_flight + int'(alloc) - int'(m_cval);
    m_cval = retire;
    if (retire) begin
      m_cseq = order_q[0];
      done_bits[order_q[0]] = 1'b0;
      void'(order_q.pop_front());
    end
    if (sel >= 0 && !row.stall) begin
      pend_q.push_back(win_seq[sel]);
      win_seq.delete(sel);
      win_tag.delete(sel);
    end
    if (alloc) begin
      win_seq.push_back(m_next);
      win_tag.push_back(int'(dispatch_tag));
      order_q.push_back(m_next);
      m_next = (m_next + 1) % NUM_SEQ;
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial begin
    row_t row;
    seed = 32'hd252b0e9;
    rst = 1'b1;
    dispatch_val = 1'b0;
    dispatch_tag = '0;
    stall = 1'b0;
    complete_val = 1'b0;
    complete_seq = '0;
    m_next = 0;
    m_flight = 0;
    m_oldest = 0;
    m_cval = 1'b0;
    m_cseq = 0;
    foreach (done_bits[i]) begin
      done_bits[i] = 1'b0;
    end
    repeat (RST_CYC) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (ROWS[r]) begin
      row = ROWS[r];
      for (int c = 0; c < int'(row.cycles); c++) begin
        check_outputs((c == 0) ? row.exp_full : ANY);
        apply_cycle(row);
        @(negedge clk);
      end
    end
    check_outputs(ANY);
    check_eq(order_q.size(), 0, "instructions left uncommitted");
    $display("Simulation PASSED");
    $finish;
  end

  // length of the table plus reset and some slack
  initial begin
    int total;
    total = RST_CYC + 2;
    foreach (ROWS[r]) total += int'(ROWS[r].cycles);
    #(total * CLK_NS + MARGIN_NS);
    $display("watchdog: run did not finish within %0d ns", total * CLK_NS + MARGIN_NS);
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/age_pkg.sv
logic/seq_alloc.sv
logic/seq_age.sv
logic/issue_window.sv
logic/commit_unit.sv
logic/age_backend.sv
testbench/tb_age_backend.sv

// ==== Makefile ====
# Verilator build for the age-tracking back end
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps -Wno-fatal
TOP      = tb_age_backend
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
	  echo "run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
